// File: design/eth_tx_pkg.sv
package eth_tx_pkg;

    // ------------------------------------------------------------------
    // basic types
    // ------------------------------------------------------------------
    typedef logic [7:0]  byte_t;      // payload and line octet
    typedef logic [15:0] bus_addr_t;  // bit 15 set selects registers
    typedef logic [15:0] bus_data_t;

    // register selects in address bits 1:0
    localparam logic [1:0] REG_LEN    = 2'd0;
    localparam logic [1:0] REG_STATUS = 2'd1;
    localparam logic [1:0] REG_COMMIT = 2'd2;

    localparam int STATUS_WRITE_DROPPED_BIT  = 0;
    localparam int STATUS_COMMIT_REFUSED_BIT = 1;

    // ------------------------------------------------------------------
    // line framing
    // ------------------------------------------------------------------
    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hD5;

    localparam int PREAMBLE_LEN   = 7;
    localparam int FCS_LEN        = 4;
    localparam int MIN_GAP_CYCLES = 12;  // idle cycles after each frame

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_PREAMBLE,
        TX_SFD,
        TX_PAYLOAD,
        TX_FCS,
        TX_GAP
    } tx_state_t;

    // reflected form of 04C11DB7
    localparam logic [31:0] CRC32_POLY = 32'hEDB8_8320;

    // One octet through the Ethernet CRC-32, bit 0 of the octet first.
    // Start from all ones and complement the result to get the FCS.
    function automatic logic [31:0] crc32_next(input logic [31:0] crc, input byte_t data);
        logic [31:0] c;
        c = crc ^ {24'd0, data};
        for (int i = 0; i < 8; i++)
        begin
            if (c[0])
                c = (c >> 1) ^ CRC32_POLY;
            else
                c = c >> 1;
        end
        return c;
    endfunction

endpackage

// File: design/host_bus_decode.sv
module host_bus_decode #(
    parameter int PACKET_SIZE = 402
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  eth_tx_pkg::bus_addr_t wb_adr,
    input  eth_tx_pkg::byte_t     wb_dat_w,
    output eth_tx_pkg::bus_data_t wb_dat_r,
    output logic                  wb_ack,
    output logic                  op_write_byte,
    output logic                  op_commit,
    output logic [14:0]           byte_offset,
    output eth_tx_pkg::byte_t     byte_value,
    input  logic [15:0]           current_len,
    input  logic                  last_commit_refused,
    input  logic [7:0]            pending_count
);
    import eth_tx_pkg::*;

    logic       new_req;
    logic       is_reg;
    logic       offset_ok;
    logic       write_dropped;
    logic [1:0] reg_sel;
    bus_data_t  status_word;

    assign new_req   = wb_cyc && wb_stb && !wb_ack;  // ack low, so not yet served
    assign is_reg    = wb_adr[15];
    assign reg_sel   = wb_adr[1:0];
    assign offset_ok = 32'(wb_adr[14:0]) < PACKET_SIZE;

    always_comb
    begin
        status_word                            = '0;
        status_word[15:8]                      = pending_count;
        status_word[STATUS_WRITE_DROPPED_BIT]  = write_dropped;
        status_word[STATUS_COMMIT_REFUSED_BIT] = last_commit_refused;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            wb_ack        <= 1'b0;
            op_write_byte <= 1'b0;
            op_commit     <= 1'b0;
            write_dropped <= 1'b0;
        end
        else
        begin
            wb_ack        <= new_req;  // single cycle, ack blocks a repeat
            op_write_byte <= new_req && wb_we && !is_reg && offset_ok;
            op_commit     <= new_req && wb_we && is_reg && (reg_sel == REG_COMMIT);
            if (new_req && wb_we && !is_reg)
                write_dropped <= !offset_ok;  // legal write clears it
        end
    end

    // operands and read data captured together with ack
    always_ff @(posedge clock)
    begin
        if (new_req)
        begin
            byte_offset <= wb_adr[14:0];
            byte_value  <= wb_dat_w;
            wb_dat_r    <= '0;  // data space reads as zero
            if (is_reg && !wb_we)
            begin
                case (reg_sel)
                    REG_LEN:    wb_dat_r <= current_len;
                    REG_STATUS: wb_dat_r <= status_word;
                    default:    wb_dat_r <= '0;
                endcase
            end
        end
    end

    ack_needs_stb: assert property (@(posedge clock) disable iff (reset) wb_ack |-> wb_stb);

endmodule

// File: design/tx_packet_buffer.sv
module tx_packet_buffer #(
    parameter int PACKET_SIZE = 402,
    parameter int SLOT_COUNT  = 8
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              op_write_byte,
    input  logic              op_commit,
    input  logic [14:0]       byte_offset,
    input  eth_tx_pkg::byte_t byte_value,
    output logic [15:0]       current_len,
    output logic              last_commit_refused,
    output logic [7:0]        pending_count,
    output logic              frame_pending,
    output logic [15:0]       frame_len,
    input  logic [15:0]       payload_index,
    output eth_tx_pkg::byte_t payload_byte,
    input  logic              frame_sent
);
    import eth_tx_pkg::*;

    localparam int SLOT_W = $clog2(SLOT_COUNT);
    localparam int OFF_W  = $clog2(PACKET_SIZE);

    byte_t             slot_mem [SLOT_COUNT][PACKET_SIZE];
    logic [15:0]       slot_len [SLOT_COUNT];  // written at commit
    logic [SLOT_W-1:0] wr_slot;
    logic [SLOT_W-1:0] send_slot;
    logic [15:0]       write_end;
    logic              commit_ok;

    assign write_end = {1'b0, byte_offset} + 16'd1;

    // one slot always stays free for the host
    assign commit_ok = op_commit && (int'(pending_count) < SLOT_COUNT - 1);

    assign frame_pending = (pending_count != 8'd0);
    assign frame_len     = slot_len[send_slot];

    // ------------------------------------------------------------------
    // pointers, counts and status
    // ------------------------------------------------------------------
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            wr_slot             <= '0;
            send_slot           <= '0;
            current_len         <= '0;
            pending_count       <= '0;
            last_commit_refused <= 1'b0;
        end
        else
        begin
            if (op_commit)
                last_commit_refused <= !commit_ok;

            if (commit_ok)
            begin
                wr_slot     <= wr_slot + SLOT_W'(1);  // wraps, count is a power of two
                current_len <= '0;
            end
            else if (op_write_byte && (write_end > current_len))
            begin
                current_len <= write_end;  // highest offset plus one
            end

            if (frame_sent)
                send_slot <= send_slot + SLOT_W'(1);

            pending_count <= pending_count + 8'(commit_ok) - 8'(frame_sent);
        end
    end

    // ------------------------------------------------------------------
    // slot storage
    // ------------------------------------------------------------------
    always_ff @(posedge clock)
    begin
        if (op_write_byte)
            slot_mem[wr_slot][byte_offset[OFF_W-1:0]] <= byte_value;
        if (commit_ok)
            slot_len[wr_slot] <= current_len;
        payload_byte <= slot_mem[send_slot][payload_index[OFF_W-1:0]];  // one cycle read
    end

    sent_needs_pending: assert property (@(posedge clock) disable iff (reset)
        frame_sent |-> frame_pending);

    pending_below_slots: assert property (@(posedge clock) disable iff (reset)
        int'(pending_count) < SLOT_COUNT);

endmodule

// File: design/tx_frame_sender.sv
module tx_frame_sender (
    input  logic              clock,
    input  logic              reset,
    input  logic              frame_pending,
    input  logic [15:0]       frame_len,
    output logic [15:0]       payload_index,
    input  eth_tx_pkg::byte_t payload_byte,
    output logic              frame_sent,
    output eth_tx_pkg::byte_t tx_data,
    output logic              tx_en
);
    import eth_tx_pkg::*;

    tx_state_t   state;
    logic [15:0] count;       // cycles spent in the current state
    logic [15:0] len_q;
    logic [31:0] crc;
    logic [31:0] fcs;
    logic [15:0] next_index;

    assign fcs = ~crc;

    // stop the prefetch at the last payload byte
    assign next_index = (payload_index + 16'd1 < len_q) ? payload_index + 16'd1 : payload_index;

    always_comb
    begin
        case (state)
            TX_PREAMBLE: tx_data = PREAMBLE_BYTE;
            TX_SFD:      tx_data = SFD_BYTE;
            TX_PAYLOAD:  tx_data = payload_byte;  // fetched one cycle earlier
            TX_FCS:      tx_data = fcs[8*count[1:0] +: 8];  // low byte first
            default:     tx_data = '0;
        endcase
    end

    // ------------------------------------------------------------------
    // frame sequencing
    // ------------------------------------------------------------------
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state         <= TX_IDLE;
            tx_en         <= 1'b0;
            frame_sent    <= 1'b0;
            count         <= '0;
            payload_index <= '0;
        end
        else
        begin
            frame_sent <= 1'b0;
            case (state)
                TX_IDLE:
                begin
                    if (frame_pending)
                    begin
                        state         <= TX_PREAMBLE;
                        tx_en         <= 1'b1;
                        count         <= '0;
                        payload_index <= '0;  // index 0 ready before payload
                    end
                end
                TX_PREAMBLE:
                begin
                    if (count == 16'(PREAMBLE_LEN - 1))
                        state <= TX_SFD;
                    else
                        count <= count + 16'd1;
                end
                TX_SFD:
                begin
                    count         <= '0;
                    payload_index <= next_index;
                    state         <= (len_q == 16'd0) ? TX_FCS : TX_PAYLOAD;
                end
                TX_PAYLOAD:
                begin
                    payload_index <= next_index;
                    if (count == len_q - 16'd1)
                    begin
                        count <= '0;
                        state <= TX_FCS;
                    end
                    else
                    begin
                        count <= count + 16'd1;
                    end
                end
                TX_FCS:
                begin
                    if (count == 16'(FCS_LEN - 1))
                    begin
                        state      <= TX_GAP;
                        tx_en      <= 1'b0;
                        frame_sent <= 1'b1;  // frees the slot
                        count      <= '0;
                    end
                    else
                    begin
                        count <= count + 16'd1;
                    end
                end
                TX_GAP:
                begin
                    if (count == 16'(MIN_GAP_CYCLES - 1))
                        state <= TX_IDLE;
                    else
                        count <= count + 16'd1;
                end
                default:
                    state <= TX_IDLE;
            endcase
        end
    end

    // length latch and running CRC
    always_ff @(posedge clock)
    begin
        if (state == TX_IDLE)
        begin
            len_q <= frame_len;
            crc   <= 32'hFFFF_FFFF;
        end
        else if (state == TX_PAYLOAD)
        begin
            crc <= crc32_next(crc, payload_byte);
        end
    end

    line_quiet_between_frames: assert property (@(posedge clock) disable iff (reset)
        (state == TX_IDLE || state == TX_GAP) |-> !tx_en);

endmodule

// File: design/eth_tx_top.sv
module eth_tx_top #(
    parameter int PACKET_SIZE = 402,  // up to 32767
    parameter int SLOT_COUNT  = 8     // power of two
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  eth_tx_pkg::bus_addr_t wb_adr,
    input  eth_tx_pkg::byte_t     wb_dat_w,
    output eth_tx_pkg::bus_data_t wb_dat_r,
    output logic                  wb_ack,
    output eth_tx_pkg::byte_t     tx_data,
    output logic                  tx_en
);
    import eth_tx_pkg::*;

    // ------------------------------------------------------------------
    // host side
    // ------------------------------------------------------------------
    logic        op_write_byte;
    logic        op_commit;
    logic [14:0] byte_offset;
    byte_t       byte_value;
    logic [15:0] current_len;
    logic        last_commit_refused;
    logic [7:0]  pending_count;

    // line side
    logic        frame_pending;
    logic [15:0] frame_len;
    logic [15:0] payload_index;
    byte_t       payload_byte;
    logic        frame_sent;

    host_bus_decode #(
        .PACKET_SIZE(PACKET_SIZE)
    ) decode0 (
        .clock(clock), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .op_write_byte(op_write_byte), .op_commit(op_commit),
        .byte_offset(byte_offset), .byte_value(byte_value),
        .current_len(current_len), .last_commit_refused(last_commit_refused),
        .pending_count(pending_count)
    );

    tx_packet_buffer #(
        .PACKET_SIZE(PACKET_SIZE),
        .SLOT_COUNT (SLOT_COUNT)
    ) buffer0 (
        .clock(clock), .reset(reset),
        .op_write_byte(op_write_byte), .op_commit(op_commit),
        .byte_offset(byte_offset), .byte_value(byte_value),
        .current_len(current_len), .last_commit_refused(last_commit_refused),
        .pending_count(pending_count),
        .frame_pending(frame_pending), .frame_len(frame_len),
        .payload_index(payload_index), .payload_byte(payload_byte),
        .frame_sent(frame_sent)
    );

    tx_frame_sender sender0 (
        .clock(clock), .reset(reset),
        .frame_pending(frame_pending), .frame_len(frame_len),
        .payload_index(payload_index), .payload_byte(payload_byte),
        .frame_sent(frame_sent), .tx_data(tx_data), .tx_en(tx_en)
    );

endmodule

// File: verif/eth_tx_model.svh
// random source, xorshift32
logic [31:0] rng_state = 32'h2551_7420;

byte_t cur_bytes [PACKET_SIZE];  // host copy of the open slot
int    cur_len;                  // highest written offset plus one
int    model_pending;            // committed frames not yet seen to end
byte_t expected_bytes [$];       // line bytes of queued frames, back to back
int    expected_lens [$];        // payload length per queued frame

function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

// ----------------------------------------------------------------------
// Ethernet FCS, worked in the non-reflected form with input bits taken
// lsb first, then mirrored back into line order
// ----------------------------------------------------------------------
function automatic logic [31:0] reference_fcs(input int len);
    logic [31:0] shift_q;
    logic [31:0] mirrored;
    logic        feedback;
    shift_q = 32'hFFFF_FFFF;
    for (int i = 0; i < len; i++)
    begin
        for (int b = 0; b < 8; b++)
        begin
            feedback = shift_q[31] ^ cur_bytes[i][b];
            shift_q  = shift_q << 1;
            if (feedback)
                shift_q = shift_q ^ 32'h04C1_1DB7;
        end
    end
    for (int b = 0; b < 32; b++)
        mirrored[b] = shift_q[31-b];
    return ~mirrored;
endfunction

// full line image of the open slot, queued when its commit is accepted
task automatic queue_expected_frame();
    logic [31:0] fcs;
    fcs = reference_fcs(cur_len);
    repeat (PREAMBLE_LEN)
        expected_bytes.push_back(8'h55);
    expected_bytes.push_back(8'hD5);  // delimiter
    for (int i = 0; i < cur_len; i++)
        expected_bytes.push_back(cur_bytes[i]);
    for (int k = 0; k < FCS_LEN; k++)
        expected_bytes.push_back(fcs[8*k +: 8]);  // low byte first
    expected_lens.push_back(cur_len);
    model_pending++;
endtask

// File: verif/eth_tx_tb.sv
module eth_tx_tb;
    import eth_tx_pkg::*;

    localparam int PACKET_SIZE   = 402;
    localparam int SLOT_COUNT    = 8;
    localparam int RANDOM_FRAMES = 20;
    localparam int TEST_COUNT    = RANDOM_FRAMES + SLOT_COUNT;
    localparam int CYCLE_LIMIT   = TEST_COUNT * (PACKET_SIZE * 3 + 200);

    logic      clock;
    logic      reset;
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    bus_addr_t wb_adr;
    byte_t     wb_dat_w;
    bus_data_t wb_dat_r;
    logic      wb_ack;
    byte_t     tx_data;
    logic      tx_en;

    int    error_count = 0;
    int    check_count = 0;
    int    refused_count = 0;
    int    cycle_count;
    int    frames_seen = 0;
    int    low_cycles = 0;
    logic  in_frame = 1'b0;
    byte_t line_bytes [$];  // bytes of the frame now on the line

    `include "eth_tx_model.svh"

    eth_tx_top #(
        .PACKET_SIZE(PACKET_SIZE),
        .SLOT_COUNT (SLOT_COUNT)
    ) dut0 (
        .clock(clock), .reset(reset),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .tx_data(tx_data), .tx_en(tx_en)
    );

    initial
    begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic check_value(input string what, input int got, input int want);
        check_count++;
        assert (got == want)
        else
        begin
            error_count++;
            $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    // ------------------------------------------------------------------
    // Wishbone master
    // ------------------------------------------------------------------
    task automatic bus_cycle(input logic we, input bus_addr_t adr, input byte_t dat,
                             output bus_data_t rdata);
        int waited;
        waited = 0;
        @(posedge clock);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= dat;
        @(negedge clock);
        while (!wb_ack && waited < 8)
        begin
            waited++;
            @(negedge clock);
        end
        check_value("ack delay in cycles", waited, 1);
        rdata = wb_dat_r;
        @(posedge clock);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic write_byte(input int offset, input byte_t value);
        bus_data_t unused;
        bus_cycle(1'b1, bus_addr_t'(offset), value, unused);
        if (offset < PACKET_SIZE)
        begin
            cur_bytes[offset] = value;
            if (offset + 1 > cur_len)
                cur_len = offset + 1;
        end
    endtask

    task automatic read_reg(input logic [1:0] sel, output bus_data_t value);
        bus_cycle(1'b0, 16'h8000 | 16'(sel), 8'h00, value);
    endtask

    task automatic fill_frame(input int len, input logic try_drop);
        bus_data_t value;
        for (int i = 0; i < len / 2; i++)
            write_byte(int'(next_random() % len), byte_t'(next_random()));  // some land twice
        read_reg(REG_LEN, value);
        check_value("length after scattered writes", value, cur_len);
        if (try_drop)
        begin
            write_byte(PACKET_SIZE + int'(next_random() % 64), 8'hEE);
            read_reg(REG_STATUS, value);
            check_value("write dropped bit", value[STATUS_WRITE_DROPPED_BIT], 1);
            read_reg(REG_LEN, value);
            check_value("length after dropped write", value, cur_len);
        end
        for (int i = len - 1; i >= 0; i--)
            write_byte(i, byte_t'(next_random()));  // top down
        read_reg(REG_LEN, value);
        check_value("length after full write", value, len);
        read_reg(REG_STATUS, value);
        check_value("write dropped bit", value[STATUS_WRITE_DROPPED_BIT], 0);
    endtask

    task automatic commit_frame(output logic refused);
        bus_data_t value;
        logic      predicted;
        int        count_diff;
        predicted = (model_pending >= SLOT_COUNT - 1);
        bus_cycle(1'b1, 16'h8000 | 16'(REG_COMMIT), 8'h00, value);
        read_reg(REG_STATUS, value);
        refused = value[STATUS_COMMIT_REFUSED_BIT];
        if (predicted)
            check_value("commit refused bit", refused, 1);
        // status may still count a frame that the monitor has just closed
        count_diff = int'(value[15:8]) - model_pending - (predicted ? 0 : 1);
        check_count++;
        assert (count_diff == 0 || count_diff == 1)
        else
        begin
            error_count++;
            $display("[ERROR] %0t: status pending count is %0d with %0d frames in the model",
                     $time, value[15:8], model_pending);
        end
        if (refused)
        begin
            refused_count++;
            assert (model_pending >= SLOT_COUNT - 2)
            else
            begin
                error_count++;
                $display("[ERROR] %0t: commit refused with %0d frames pending", $time,
                         model_pending);
            end
        end
        else
        begin
            queue_expected_frame();
            cur_len = 0;
            read_reg(REG_LEN, value);
            check_value("length after commit", value, 0);
        end
    endtask

    task automatic commit_until_accepted();
        logic refused;
        commit_frame(refused);
        while (refused)
        begin
            while (model_pending >= SLOT_COUNT - 1)
                @(negedge clock);  // let the line free a slot
            commit_frame(refused);
        end
    endtask

    // ------------------------------------------------------------------
    // line monitor
    // ------------------------------------------------------------------
    task automatic compare_frame();
        int    len;
        byte_t want;
        assert (expected_lens.size() > 0)
        else
        begin
            error_count++;
            $display("A frame of %0d bytes appeared with none committed", line_bytes.size());
        end
        if (expected_lens.size() > 0)
        begin
            len = expected_lens.pop_front();
            check_value($sformatf("frame %0d cycles with tx_en high", frames_seen),
                        line_bytes.size(), len + PREAMBLE_LEN + 1 + FCS_LEN);
            for (int i = 0; i < len + PREAMBLE_LEN + 1 + FCS_LEN; i++)
            begin
                want = expected_bytes.pop_front();
                if (i < line_bytes.size())
                    check_value($sformatf("frame %0d byte %0d", frames_seen, i),
                                line_bytes[i], want);
            end
            model_pending--;
        end
        line_bytes.delete();
        frames_seen++;
    endtask

    always @(negedge clock)
    begin
        if (!reset)
        begin
            if (tx_en)
            begin
                if (!in_frame && frames_seen > 0)
                    check_value("gap at least 12, gap cycles", low_cycles >= MIN_GAP_CYCLES ?
                                MIN_GAP_CYCLES : low_cycles, MIN_GAP_CYCLES);
                line_bytes.push_back(tx_data);
                in_frame = 1'b1;
            end
            else if (in_frame)
            begin
                compare_frame();
                in_frame   = 1'b0;
                low_cycles = 1;  // this cycle is already idle
            end
            else
            begin
                low_cycles++;
            end
        end
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT)
        begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Checks failed");
        $finish;
    end

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    initial
    begin
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_dat_w      = '0;
        reset         = 1'b1;
        cur_len       = 0;
        model_pending = 0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_value("tx_en after reset", tx_en, 0);
        check_value("wb_ack after reset", wb_ack, 0);

        for (int f = 0; f < RANDOM_FRAMES; f++)
        begin
            fill_frame(1 + int'(next_random() % 120), (f % 4) == 1);
            commit_until_accepted();
        end

        // one long frame holds the line while short ones pile up
        fill_frame(PACKET_SIZE, 1'b0);
        commit_until_accepted();
        for (int k = 0; k < SLOT_COUNT - 1; k++)
        begin
            fill_frame(1 + int'(next_random() % 3), 1'b0);
            commit_until_accepted();
        end
        assert (refused_count > 0)
        else
        begin
            error_count++;
            $display("No commit was refused while the slots were full");
        end

        while (expected_lens.size() > 0 || tx_en)
            @(negedge clock);
        $display("Summary: %0d checks, %0d errors, %0d frames, %0d refused commits",
                 check_count, error_count, frames_seen, refused_count);
        if (error_count == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// File: sim.f
+incdir+verif
design/eth_tx_pkg.sv
design/host_bus_decode.sv
design/tx_packet_buffer.sv
design/tx_frame_sender.sv
design/eth_tx_top.sv
verif/eth_tx_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert -Wno-fatal -j 0
TOP       := eth_tx_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) verif/eth_tx_model.svh
PASS_MSG  := All checks passed

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
